//--- source/saturn_decoder_pkg.sv
package saturn_decoder_pkg;

  // one opcode or data nibble
  typedef logic [3:0] nibble_t;

  // saturn program address, 5 nibbles
  typedef logic [19:0] addr_t;

  // operation handed to the alu
  typedef enum logic [4:0] {
    ALU_OP_NONE,
    ALU_OP_ZERO,
    ALU_OP_COPY,
    ALU_OP_EXCH,
    ALU_OP_INC,
    ALU_OP_DEC,
    ALU_OP_JMP_REL2,
    ALU_OP_JMP_REL3
  } alu_op_e;

  // where the next nibble of the instruction belongs
  typedef enum logic [2:0] {
    BLK_FIRST,
    BLK_0X,
    BLK_2X,
    BLK_3X,
    BLK_OPERAND,
    BLK_HALT
  } dec_block_e;

  // operand register capacity in nibbles
  localparam int OPERAND_NIBBLES = 16;

  // nibble k lives at bits 4k+3 .. 4k
  typedef logic [OPERAND_NIBBLES*4-1:0] operand_t;

  // nibble count or position, must reach 16
  typedef logic [4:0] opcount_t;

  // offset lengths of the relative jumps
  // 4xy / 5xy
  localparam int GOC_OFFSET_NIBBLES  = 2;
  // 6xxx / 7xxx
  localparam int GOTO_OFFSET_NIBBLES = 3;

endpackage

//--- source/decode_sequencer.sv
`timescale 1ns/1ps

module decode_sequencer
  import saturn_decoder_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_en_dec,
  input  logic       i_stalled,
  input  logic       i_op_last,
  input  addr_t      i_pc,
  input  nibble_t    i_nibble,
  output logic       o_accept,
  output logic       o_first,
  output logic       o_op_start,
  output opcount_t   o_op_count,
  output dec_block_e o_block,
  output logic       o_ins_decoded,
  output logic       o_dec_error,
  output addr_t      o_ins_addr
);

  // nibble consumed this cycle
  // halted decoder never consumes again
  assign o_accept = i_en_dec && !i_stalled && (o_block != BLK_HALT);

  // opening nibble of an instruction
  assign o_first  = o_accept && (o_block == BLK_FIRST);

  // operand setup, given during the nibble that opens the operand
  always_comb begin
    o_op_start = 1'b0;
    o_op_count = '0;
    if (o_accept) begin
      case (o_block)
        BLK_FIRST: begin
          case (i_nibble)
            // goc / gonc, 2 offset nibbles
            4'h4, 4'h5: begin
              o_op_start = 1'b1;
              o_op_count = opcount_t'(GOC_OFFSET_NIBBLES);
            end
            // goto / gosub, 3 offset nibbles
            4'h6, 4'h7: begin
              o_op_start = 1'b1;
              o_op_count = opcount_t'(GOTO_OFFSET_NIBBLES);
            end
            default: begin
              o_op_start = 1'b0;
            end
          endcase
        end
        // lc: n+1 hex nibbles follow
        BLK_3X: begin
          o_op_start = 1'b1;
          o_op_count = {1'b0, i_nibble} + 5'd1;
        end
        default: begin
          o_op_start = 1'b0;
        end
      endcase
    end
  end

  // block walk and end-of-instruction strobe
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_block       <= BLK_FIRST;
      o_ins_decoded <= 1'b0;
      o_dec_error   <= 1'b0;
    end else begin
      // decoded is a single-cycle pulse
      o_ins_decoded <= 1'b0;
      if (o_accept) begin
        case (o_block)
          BLK_FIRST: begin
            case (i_nibble)
              4'h0: o_block <= BLK_0X;
              4'h2: o_block <= BLK_2X;
              4'h3: o_block <= BLK_3X;
              4'h4, 4'h5, 4'h6, 4'h7: o_block <= BLK_OPERAND;
              // groups not handled here, sticky error
              default: begin
                o_block     <= BLK_HALT;
                o_dec_error <= 1'b1;
              end
            endcase
          end
          BLK_0X: begin
            // 0E needs the field tables
            if (i_nibble == 4'hE) begin
              o_block     <= BLK_HALT;
              o_dec_error <= 1'b1;
            end else begin
              o_block       <= BLK_FIRST;
              o_ins_decoded <= 1'b1;
            end
          end
          // P=n, done on the second nibble
          BLK_2X: begin
            o_block       <= BLK_FIRST;
            o_ins_decoded <= 1'b1;
          end
          // count nibble, operand follows
          BLK_3X: o_block <= BLK_OPERAND;
          BLK_OPERAND: begin
            // collector flags the final nibble
            if (i_op_last) begin
              o_block       <= BLK_FIRST;
              o_ins_decoded <= 1'b1;
            end
          end
          default: o_block <= BLK_HALT;
        endcase
      end
    end
  end

  // instruction start address
  always_ff @(posedge i_clk) begin
    if (o_first) begin
      o_ins_addr <= i_pc;
    end
  end

  // failing instruction never reports as decoded
  assert property (@(posedge i_clk) disable iff (i_reset)
    !(o_ins_decoded && $rose(o_dec_error)));

  // operand setup only on a consumed nibble
  assert property (@(posedge i_clk) disable iff (i_reset)
    o_op_start |-> o_accept);

endmodule

//--- source/control_decode.sv
`timescale 1ns/1ps

module control_decode
  import saturn_decoder_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_accept,
  input  logic       i_first,
  input  dec_block_e i_block,
  input  nibble_t    i_nibble,
  output alu_op_e    o_alu_op,
  output logic       o_ins_alu_op,
  output logic       o_push,
  output logic       o_pop,
  output logic       o_ins_rtn,
  output logic       o_set_xm,
  output logic       o_set_carry,
  output logic       o_carry_val,
  output logic       o_en_intr,
  output logic       o_ins_set_mode,
  output logic       o_mode_dec,
  output logic       o_test_carry
);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_alu_op       <= ALU_OP_NONE;
      o_ins_alu_op   <= 1'b0;
      o_push         <= 1'b0;
      o_pop          <= 1'b0;
      o_ins_rtn      <= 1'b0;
      o_set_xm       <= 1'b0;
      o_set_carry    <= 1'b0;
      o_carry_val    <= 1'b0;
      o_en_intr      <= 1'b0;
      o_ins_set_mode <= 1'b0;
      o_mode_dec     <= 1'b0;
      o_test_carry   <= 1'b0;
    end else if (i_first) begin
      // new instruction, drop the previous controls
      o_ins_alu_op   <= 1'b0;
      o_pop          <= 1'b0;
      o_ins_rtn      <= 1'b0;
      o_set_xm       <= 1'b0;
      o_set_carry    <= 1'b0;
      o_en_intr      <= 1'b0;
      o_ins_set_mode <= 1'b0;
      o_mode_dec     <= 1'b0;
      // goc tests carry set, gonc carry clear
      o_test_carry   <= (i_nibble == 4'h4) || (i_nibble == 4'h5);
      o_carry_val    <= (i_nibble == 4'h4);
      // gosub pushes the return address
      o_push         <= (i_nibble == 4'h7);
      case (i_nibble)
        4'h4, 4'h5: o_alu_op <= ALU_OP_JMP_REL2;
        4'h6, 4'h7: o_alu_op <= ALU_OP_JMP_REL3;
        default:    o_alu_op <= ALU_OP_NONE;
      endcase
    end else if (i_accept) begin
      case (i_block)
        BLK_0X: begin
          case (i_nibble)
            // rtnsxm rtn rtnsc rtncc rti
            4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
              o_ins_rtn   <= 1'b1;
              o_pop       <= 1'b1;
              o_set_xm    <= (i_nibble == 4'h0);
              o_set_carry <= (i_nibble == 4'h2) || (i_nibble == 4'h3);
              o_carry_val <= (i_nibble == 4'h2);
              o_en_intr   <= (i_nibble == 4'hF);
            end
            // sethex / setdec
            4'h4, 4'h5: begin
              o_ins_set_mode <= 1'b1;
              o_mode_dec     <= i_nibble[0];
            end
            // rstk=c pushes, c=rstk pops
            4'h6, 4'h7: begin
              o_ins_alu_op <= 1'b1;
              o_alu_op     <= ALU_OP_COPY;
              o_push       <= !i_nibble[0];
              o_pop        <= i_nibble[0];
            end
            // clrst
            4'h8: begin
              o_ins_alu_op <= 1'b1;
              o_alu_op     <= ALU_OP_ZERO;
            end
            // c=st, st=c
            4'h9, 4'hA: begin
              o_ins_alu_op <= 1'b1;
              o_alu_op     <= ALU_OP_COPY;
            end
            // cstex
            4'hB: begin
              o_ins_alu_op <= 1'b1;
              o_alu_op     <= ALU_OP_EXCH;
            end
            // p=p+1 / p=p-1
            4'hC, 4'hD: begin
              o_ins_alu_op <= 1'b1;
              o_alu_op     <= i_nibble[0] ? ALU_OP_DEC : ALU_OP_INC;
            end
            // 0E halts in the sequencer
            default: ;
          endcase
        end
        // p=n and lc load a constant
        BLK_2X, BLK_3X: begin
          o_ins_alu_op <= 1'b1;
          o_alu_op     <= ALU_OP_COPY;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- source/operand_collector.sv
`timescale 1ns/1ps

module operand_collector
  import saturn_decoder_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_accept,
  input  logic       i_op_start,
  input  opcount_t   i_op_count,
  input  dec_block_e i_block,
  input  nibble_t    i_nibble,
  output logic       o_op_last,
  output nibble_t    o_imm_value,
  output operand_t   o_mem_load,
  output opcount_t   o_mem_pos
);

  // nibbles expected for the current operand
  opcount_t op_total;

  logic     take_operand;

  assign take_operand = i_accept && (i_block == BLK_OPERAND);

  // final operand nibble arriving now
  assign o_op_last = take_operand && ((o_mem_pos + 5'd1) == op_total);

  // count and write position
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      op_total  <= '0;
      o_mem_pos <= '0;
    end else if (i_op_start) begin
      op_total  <= i_op_count;
      o_mem_pos <= '0;
    end else if (take_operand) begin
      o_mem_pos <= o_mem_pos + 5'd1;
    end
  end

  // operand nibbles, lowest first
  always_ff @(posedge i_clk) begin
    if (i_op_start) begin
      // unused upper nibbles read as zero
      o_mem_load <= '0;
    end else if (take_operand) begin
      o_mem_load[4*o_mem_pos[3:0] +: 4] <= i_nibble;
      o_imm_value                       <= i_nibble;
    end else if (i_accept && (i_block == BLK_2X)) begin
      // p=n carries its value in the second nibble
      o_imm_value <= i_nibble;
    end
  end

  // position stays inside the operand and the register
  assert property (@(posedge i_clk) disable iff (i_reset)
    (o_mem_pos <= op_total) && (o_mem_pos <= opcount_t'(OPERAND_NIBBLES)));

endmodule

//--- source/saturn_decoder.sv
`timescale 1ns/1ps

module saturn_decoder
  import saturn_decoder_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_en_dec,
  input  logic     i_stalled,
  input  addr_t    i_pc,
  input  nibble_t  i_nibble,
  output logic     o_ins_decoded,
  output logic     o_dec_error,
  output addr_t    o_ins_addr,
  output alu_op_e  o_alu_op,
  output logic     o_ins_alu_op,
  output logic     o_push,
  output logic     o_pop,
  output logic     o_ins_rtn,
  output logic     o_set_xm,
  output logic     o_set_carry,
  output logic     o_carry_val,
  output logic     o_en_intr,
  output logic     o_ins_set_mode,
  output logic     o_mode_dec,
  output logic     o_test_carry,
  output nibble_t  o_imm_value,
  output operand_t o_mem_load,
  output opcount_t o_mem_pos
);

  // sequencer to the two decode halves
  logic       accept;
  logic       first;
  logic       op_start;
  opcount_t   op_count;
  dec_block_e block;
  // collector back to the sequencer
  logic       op_last;

  decode_sequencer u_sequencer (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_en_dec      (i_en_dec),
    .i_stalled     (i_stalled),
    .i_op_last     (op_last),
    .i_pc          (i_pc),
    .i_nibble      (i_nibble),
    .o_accept      (accept),
    .o_first       (first),
    .o_op_start    (op_start),
    .o_op_count    (op_count),
    .o_block       (block),
    .o_ins_decoded (o_ins_decoded),
    .o_dec_error   (o_dec_error),
    .o_ins_addr    (o_ins_addr)
  );

  control_decode u_control (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_accept       (accept),
    .i_first        (first),
    .i_block        (block),
    .i_nibble       (i_nibble),
    .o_alu_op       (o_alu_op),
    .o_ins_alu_op   (o_ins_alu_op),
    .o_push         (o_push),
    .o_pop          (o_pop),
    .o_ins_rtn      (o_ins_rtn),
    .o_set_xm       (o_set_xm),
    .o_set_carry    (o_set_carry),
    .o_carry_val    (o_carry_val),
    .o_en_intr      (o_en_intr),
    .o_ins_set_mode (o_ins_set_mode),
    .o_mode_dec     (o_mode_dec),
    .o_test_carry   (o_test_carry)
  );

  operand_collector u_operand (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_accept    (accept),
    .i_op_start  (op_start),
    .i_op_count  (op_count),
    .i_block     (block),
    .i_nibble    (i_nibble),
    .o_op_last   (op_last),
    .o_imm_value (o_imm_value),
    .o_mem_load  (o_mem_load),
    .o_mem_pos   (o_mem_pos)
  );

endmodule

//--- sim/tb_saturn_decoder.sv
`timescale 1ns/1ps

module tb_saturn_decoder
  import saturn_decoder_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 40;

  logic     i_clk = 1'b0;
  logic     i_reset;
  logic     i_en_dec;
  logic     i_stalled;
  addr_t    i_pc;
  nibble_t  i_nibble;
  logic     o_ins_decoded;
  logic     o_dec_error;
  addr_t    o_ins_addr;
  alu_op_e  o_alu_op;
  logic     o_ins_alu_op;
  logic     o_push;
  logic     o_pop;
  logic     o_ins_rtn;
  logic     o_set_xm;
  logic     o_set_carry;
  logic     o_carry_val;
  logic     o_en_intr;
  logic     o_ins_set_mode;
  logic     o_mode_dec;
  logic     o_test_carry;
  nibble_t  o_imm_value;
  operand_t o_mem_load;
  opcount_t o_mem_pos;

  // nibbles of the instruction under test
  nibble_t  ins_q[$];
  // free-running edge count, for latency checks
  int       cycle_cnt = 0;

  saturn_decoder i_dut (.*);

  always #5 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_alu_op(input string name, input alu_op_e exp, input alu_op_e act);
    if (act !== exp) begin
      abort_run($sformatf("error: time %0t signal %s expected %s actual %s",
                          $time, name, exp.name(), act.name()));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("error: time %0t signal %s expected %b actual %b",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_nibble(input string name, input nibble_t exp, input nibble_t act);
    if (act !== exp) begin
      abort_run($sformatf("error: time %0t signal %s expected %h actual %h",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_operand(input string name, input operand_t exp, input operand_t act);
    if (act !== exp) begin
      abort_run($sformatf("error: time %0t signal %s expected %h actual %h",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input opcount_t exp, input opcount_t act);
    if (act !== exp) begin
      abort_run($sformatf("error: time %0t signal %s expected %0d actual %0d",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("error: time %0t signal %s expected %h actual %h",
                          $time, name, exp, act));
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_edge();
    @(posedge i_clk);
    #1;
  endtask

  task automatic apply_reset();
    i_reset  = 1'b1;
    i_en_dec = 1'b0;
    repeat (8) next_edge();
    i_reset = 1'b0;
    check_flag("o_ins_decoded", 1'b0, o_ins_decoded);
    check_flag("o_dec_error", 1'b0, o_dec_error);
    check_flag("o_push", 1'b0, o_push);
    check_flag("o_pop", 1'b0, o_pop);
    check_flag("o_ins_rtn", 1'b0, o_ins_rtn);
    check_flag("o_ins_set_mode", 1'b0, o_ins_set_mode);
    check_flag("o_ins_alu_op", 1'b0, o_ins_alu_op);
    check_flag("o_test_carry", 1'b0, o_test_carry);
    check_alu_op("o_alu_op", ALU_OP_NONE, o_alu_op);
  endtask

  // refused cycles first, then one accepted nibble
  task automatic send_nibble(input nibble_t nib, input addr_t pc, input int stalls);
    repeat (stalls) begin
      // either a stall or a low enable holds the nibble off
      if ($urandom_range(1, 0) == 1) begin
        i_stalled = 1'b1;
        i_en_dec  = 1'b1;
      end else begin
        i_stalled = 1'b0;
        i_en_dec  = 1'b0;
      end
      // junk on the bus while refused
      i_nibble = nibble_t'($urandom_range(15, 0));
      next_edge();
    end
    i_stalled = 1'b0;
    i_en_dec  = 1'b1;
    i_nibble  = nib;
    i_pc      = pc;
    next_edge();
    i_en_dec = 1'b0;
  endtask

  task automatic wait_decoded(output int seen_cycle);
    int waited;
    waited = 0;
    while (o_ins_decoded !== 1'b1) begin
      if (waited >= TIMEOUT_CYCLES) begin
        abort_run("timeout: o_ins_decoded never went high");
      end
      next_edge();
      waited++;
    end
    seen_cycle = cycle_cnt;
  endtask

  // sends ins_q, ends in the strobe cycle
  task automatic run_ins(input addr_t pc, input int max_stall);
    int start;
    int stall;
    int total;
    int done_cycle;
    start = cycle_cnt;
    total = 0;
    for (int k = 0; k < ins_q.size(); k++) begin
      stall = (max_stall > 0) ? $urandom_range(max_stall, 0) : 0;
      total += stall;
      send_nibble(ins_q[k], pc + addr_t'(k), stall);
      if (k < ins_q.size() - 1) begin
        check_flag("o_ins_decoded", 1'b0, o_ins_decoded);
      end
    end
    wait_decoded(done_cycle);
    // one cycle per nibble plus one per refused cycle
    if (done_cycle != start + ins_q.size() + total) begin
      abort_run($sformatf("o_ins_decoded came at cycle %0d, expected cycle %0d",
                          done_cycle, start + ins_q.size() + total));
    end
    check_addr("o_ins_addr", pc, o_ins_addr);
  endtask

  // all control outputs, then the strobe must drop
  task automatic check_controls(input alu_op_e alu, input logic ins_alu, push, pop, rtn,
                                set_xm, set_carry, carry_val, en_intr, set_mode,
                                mode_dec, test_carry);
    check_alu_op("o_alu_op", alu, o_alu_op);
    check_flag("o_ins_alu_op", ins_alu, o_ins_alu_op);
    check_flag("o_push", push, o_push);
    check_flag("o_pop", pop, o_pop);
    check_flag("o_ins_rtn", rtn, o_ins_rtn);
    check_flag("o_set_xm", set_xm, o_set_xm);
    check_flag("o_set_carry", set_carry, o_set_carry);
    check_flag("o_carry_val", carry_val, o_carry_val);
    check_flag("o_en_intr", en_intr, o_en_intr);
    check_flag("o_ins_set_mode", set_mode, o_ins_set_mode);
    check_flag("o_mode_dec", mode_dec, o_mode_dec);
    check_flag("o_test_carry", test_carry, o_test_carry);
    next_edge();
    check_flag("o_ins_decoded", 1'b0, o_ins_decoded);
    // held until the next first nibble
    check_alu_op("o_alu_op", alu, o_alu_op);
  endtask

  // 00 01 02 03 0F
  task automatic test_returns(input int max_stall);
    nibble_t nibs[5];
    nibble_t nib;
    nibs = '{4'h0, 4'h1, 4'h2, 4'h3, 4'hF};
    foreach (nibs[i]) begin
      nib = nibs[i];
      ins_q.delete();
      ins_q.push_back(4'h0);
      ins_q.push_back(nib);
      run_ins(addr_t'($urandom), max_stall);
      check_controls(ALU_OP_NONE, 1'b0, 1'b0, 1'b1, 1'b1, nib == 4'h0,
                     (nib == 4'h2) || (nib == 4'h3), nib == 4'h2, nib == 4'hF,
                     1'b0, 1'b0, 1'b0);
    end
  endtask

  // 04 to 0D
  task automatic test_other_0x(input int max_stall);
    nibble_t nib;
    alu_op_e alu;
    for (int n = 4; n <= 13; n++) begin
      nib = nibble_t'(n);
      ins_q.delete();
      ins_q.push_back(4'h0);
      ins_q.push_back(nib);
      run_ins(addr_t'($urandom), max_stall);
      case (nib)
        4'h4, 4'h5: alu = ALU_OP_NONE;
        4'h8:       alu = ALU_OP_ZERO;
        4'hB:       alu = ALU_OP_EXCH;
        4'hC:       alu = ALU_OP_INC;
        4'hD:       alu = ALU_OP_DEC;
        default:    alu = ALU_OP_COPY;
      endcase
      // sethex/setdec touch only the mode pair
      check_controls(alu, n >= 6, nib == 4'h6, nib == 4'h7, 1'b0, 1'b0, 1'b0, 1'b0,
                     1'b0, n <= 5, nib == 4'h5, 1'b0);
    end
  endtask

  // P=n, then LC with n+1 nibbles
  task automatic test_immediates(input int max_stall);
    nibble_t  nib;
    nibble_t  data;
    operand_t exp_load;
    for (int n = 0; n < 16; n++) begin
      nib = nibble_t'(n);
      ins_q.delete();
      ins_q.push_back(4'h2);
      ins_q.push_back(nib);
      run_ins(addr_t'($urandom), max_stall);
      check_nibble("o_imm_value", nib, o_imm_value);
      check_controls(ALU_OP_COPY, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                     1'b0, 1'b0, 1'b0);
    end
    for (int n = 0; n < 16; n++) begin
      nib = nibble_t'(n);
      exp_load = '0;
      ins_q.delete();
      ins_q.push_back(4'h3);
      ins_q.push_back(nib);
      for (int k = 0; k <= n; k++) begin
        data = nibble_t'($urandom_range(15, 0));
        ins_q.push_back(data);
        exp_load[4*k +: 4] = data;
      end
      run_ins(addr_t'($urandom), max_stall);
      check_operand("o_mem_load", exp_load, o_mem_load);
      check_count("o_mem_pos", opcount_t'(n + 1), o_mem_pos);
      check_controls(ALU_OP_COPY, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                     1'b0, 1'b0, 1'b0);
    end
  endtask

  // goc gonc goto gosub
  task automatic test_jumps(input int max_stall);
    nibble_t  nib;
    nibble_t  data;
    operand_t exp_load;
    int       len;
    for (int n = 4; n < 8; n++) begin
      nib = nibble_t'(n);
      len = (n < 6) ? GOC_OFFSET_NIBBLES : GOTO_OFFSET_NIBBLES;
      exp_load = '0;
      ins_q.delete();
      ins_q.push_back(nib);
      for (int k = 0; k < len; k++) begin
        data = nibble_t'($urandom_range(15, 0));
        ins_q.push_back(data);
        exp_load[4*k +: 4] = data;
      end
      run_ins(addr_t'($urandom), max_stall);
      check_operand("o_mem_load", exp_load, o_mem_load);
      check_count("o_mem_pos", opcount_t'(len), o_mem_pos);
      check_controls((n < 6) ? ALU_OP_JMP_REL2 : ALU_OP_JMP_REL3, 1'b0, nib == 4'h7,
                     1'b0, 1'b0, 1'b0, 1'b0, nib == 4'h4, 1'b0, 1'b0, 1'b0, n < 6);
    end
  endtask

  // ins_q holds an illegal sequence, decoder must stay halted
  task automatic test_error_halt();
    addr_t pc;
    pc = addr_t'($urandom);
    for (int k = 0; k < ins_q.size(); k++) begin
      send_nibble(ins_q[k], pc + addr_t'(k), 0);
      if (k < ins_q.size() - 1) begin
        check_flag("o_dec_error", 1'b0, o_dec_error);
      end
    end
    check_flag("o_dec_error", 1'b1, o_dec_error);
    check_flag("o_ins_decoded", 1'b0, o_ins_decoded);
    // a legal RTN afterwards is ignored
    send_nibble(4'h0, pc + 20'h10, 0);
    send_nibble(4'h1, pc + 20'h11, 0);
    repeat (TIMEOUT_CYCLES) begin
      check_flag("o_ins_decoded", 1'b0, o_ins_decoded);
      check_flag("o_dec_error", 1'b1, o_dec_error);
      next_edge();
    end
  endtask

  initial begin
    i_reset   = 1'b1;
    i_en_dec  = 1'b0;
    i_stalled = 1'b0;
    i_pc      = '0;
    i_nibble  = '0;
    void'($urandom(32'h234a_6baa));
    apply_reset();
    test_returns(0);
    test_other_0x(0);
    test_immediates(0);
    test_jumps(0);
    // same again with refused cycles between nibbles
    test_returns(4);
    test_other_0x(4);
    test_immediates(4);
    test_jumps(4);
    ins_q.delete();
    ins_q.push_back(4'h8);
    test_error_halt();
    apply_reset();
    ins_q.delete();
    ins_q.push_back(4'h0);
    ins_q.push_back(4'hE);
    test_error_halt();
    $display("sim passed");
    $finish;
  end

endmodule

//--- files.f
source/saturn_decoder_pkg.sv
source/decode_sequencer.sv
source/control_decode.sv
source/operand_collector.sv
source/saturn_decoder.sv
sim/tb_saturn_decoder.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  --top-module tb_saturn_decoder \
  --Mdir obj_dir \
  -o tb_saturn_decoder \
  -f files.f
./obj_dir/tb_saturn_decoder
